/* src/sysmgr_pkg.sv */
`default_nettype none

package sysmgr_pkg;

	// PLL model

	// Board clock edges after reset release before the PLL reports lock
	localparam logic [15:0] pll_lock_cycles = 16'd32;

	// Read clock delay added per step of the dynamic delay code
	localparam int delay_step_ps = 150;

	// Clock and reset generator

	// Slow clock edges that lock must be stable before rst is released
	localparam logic [15:0] rst_hold_cycles = 16'd16;

	// Word alignment strobes

	// Fast clock cycle (of four per slow period) that carries the strobe.
	// Counted from the slow clock rising edge, first fast cycle is 0
	localparam logic [1:0] sync_phase = 2'd2;

	// Reset sequencer states
	//   crg_wait_lock : rst held, waiting for synchronized lock
	//   crg_hold      : lock seen, counting out the hold time
	//   crg_run       : rst released
	typedef enum logic [1:0] {
		crg_wait_lock = 2'd0,
		crg_hold      = 2'd1,
		crg_run       = 2'd2
	} crg_state_t;

endpackage

`default_nettype wire

/* src/pll_model.sv */
`default_nettype none

module pll_model (
	input  wire logic       clk_in,
	input  wire logic       reset,
	input  wire logic [3:0] delay,
	output logic            clk_4x,
	output logic            clk_rd,
	output logic            pll_lock
);

	timeunit 1ns;
	timeprecision 1ps;

	import sysmgr_pkg::*;

	logic [15:0] lock_cnt;
	logic        gate_en = 1'b0;
	realtime     rd_delay;

	// Lock detector
	// Counts board clock edges once reset is gone, lock stays up until reset
	always_ff @(posedge clk_in) begin
		if (reset) begin
			lock_cnt <= 16'd0;
			pll_lock <= 1'b0;
		end else if (!pll_lock) begin
			lock_cnt <= lock_cnt + 16'd1;
			if (lock_cnt == pll_lock_cycles - 16'd1) begin
				pll_lock <= 1'b1;
			end
		end
	end

	// Output gate
	// Enable changes only while clk_in is low so no runt pulses reach clk_4x
	always_ff @(negedge clk_in) begin
		gate_en <= pll_lock;
	end

	// Unity ratio in this model, the fast clock is the gated board clock
	assign clk_4x = clk_in & gate_en;

	// Dynamic delay
	// One step of delay_step_ps per delay code, applied to both edges
	always_comb begin
		rd_delay = real'(delay) * real'(delay_step_ps) * 1ps;
	end

	// Nonblocking with intra-assignment delay keeps every edge (transport)
	always @(clk_4x) begin
		clk_rd <= #(rd_delay) clk_4x;
	end

	// Lock may only come up on an edge that saw reset low
	a_lock_not_in_reset: assert property (
		@(posedge clk_in) $rose(pll_lock) |-> !$past(reset)
	) else $error("pll_model: pll_lock rose while reset was high");

endmodule

`default_nettype wire

/* src/serdes_crg.sv */
`default_nettype none

module serdes_crg (
	input  wire logic clk_4x,
	input  wire logic pll_lock,
	output logic      clk_1x,
	output logic      clk_2x,
	output logic      rst
);

	import sysmgr_pkg::*;

	// Power-up values come from the FPGA flop init, there is no clock yet
	logic        div_2x    = 1'b0;
	logic        div_1x    = 1'b0;
	logic        lock_meta = 1'b0;
	logic        lock_sync = 1'b0;
	logic        rst_q     = 1'b1;
	crg_state_t  state     = crg_wait_lock;
	logic [15:0] hold_cnt;

	// Clock dividers

	// Half rate
	always @(posedge clk_4x) begin
		div_2x <= ~div_2x;
	end

	// Quarter rate, clocked from the half rate output
	always @(posedge div_2x) begin
		div_1x <= ~div_1x;
	end

	assign clk_2x = div_2x;
	assign clk_1x = div_1x;

	// Lock synchronizer
	// The PLL gates its outputs off when it loses lock, so clk_1x stops.
	// Loss of lock therefore has to clear this pair without a clock edge,
	// and release is still two clean clk_1x edges
	always @(posedge div_1x or negedge pll_lock) begin
		if (!pll_lock) begin
			lock_meta <= 1'b0;
			lock_sync <= 1'b0;
		end else begin
			lock_meta <= 1'b1;
			lock_sync <= lock_meta;
		end
	end

	// Reset sequencer
	always @(posedge div_1x) begin
		case (state)
			crg_wait_lock: begin
				rst_q <= 1'b1;
				if (lock_sync) begin
					state    <= crg_hold;
					// Two synchronizer edges already spent since lock was sampled
					hold_cnt <= 16'd2;
				end
			end

			crg_hold: begin
				if (!lock_sync) begin
					state <= crg_wait_lock;
				end else if (hold_cnt == rst_hold_cycles - 16'd1) begin
					state <= crg_run;
					rst_q <= 1'b0;
				end else begin
					hold_cnt <= hold_cnt + 16'd1;
				end
			end

			crg_run: begin
				if (!lock_sync) begin
					state <= crg_wait_lock;
					rst_q <= 1'b1;
				end
			end

			default: begin
				state <= crg_wait_lock;
				rst_q <= 1'b1;
			end
		endcase
	end

	// Immediate assertion on lock loss, release only from the sequencer
	assign rst = rst_q | ~lock_sync;

	// Once synchronized lock is seen low, the sequencer reset flop
	// is set by the following slow clock edge
	a_rst_follows_lock: assert property (
		@(posedge div_1x) !lock_sync |=> rst_q
	) else $error("serdes_crg: rst not held while synchronized lock is low");

endmodule

`default_nettype wire

/* src/serdes_sync.sv */
`default_nettype none

module serdes_sync (
	input  wire logic clk_slow,
	input  wire logic clk_fast,
	input  wire logic rst,
	output logic      sync
);

	import sysmgr_pkg::*;

	logic       slow_meta;
	logic       slow_prev;
	logic       slow_rise;
	logic [1:0] phase_cnt;
	logic [1:0] phase_nxt;

	// Slow clock sampled as data in the fast domain
	always_ff @(posedge clk_fast) begin
		slow_meta <= clk_slow;
		slow_prev <= slow_meta;
	end

	// High for one fast cycle after each slow rising edge
	assign slow_rise = slow_meta & ~slow_prev;

	// Phase counter
	// The edge shows up two fast edges late, so the counter is loaded
	// with that offset and then tracks the cycle index in the slow period
	always_comb begin
		if (slow_rise) begin
			phase_nxt = 2'd2;
		end else begin
			phase_nxt = phase_cnt + 2'd1;
		end
	end

	always_ff @(posedge clk_fast) begin
		if (rst) begin
			phase_cnt <= 2'd0;
		end else begin
			phase_cnt <= phase_nxt;
		end
	end

	// Strobe register
	// Decoded from the next count so the strobe lines up with its cycle
	always_ff @(posedge clk_fast) begin
		if (rst) begin
			sync <= 1'b0;
		end else begin
			sync <= (phase_nxt == sync_phase);
		end
	end

	// One fast cycle wide, never back to back
	a_sync_single: assert property (
		@(posedge clk_fast) sync |=> !sync
	) else $error("serdes_sync: strobe high in consecutive fast cycles");

endmodule

`default_nettype wire

/* src/sysmgr.sv */
`default_nettype none

module sysmgr (
	input  wire logic       clk_in,
	input  wire logic       reset,
	input  wire logic [3:0] delay,
	output logic            clk_1x,
	output logic            clk_2x,
	output logic            clk_4x,
	output logic            clk_rd,
	output logic            sync_4x,
	output logic            sync_rd,
	output logic            rst
);

	logic pll_lock;

	// PLL
	// clk_4x is the main fast clock, clk_rd is the same clock shifted
	// by the dynamic delay for read data capture
	pll_model u_pll (
		.clk_in   (clk_in),
		.reset    (reset),
		.delay    (delay),
		.clk_4x   (clk_4x),
		.clk_rd   (clk_rd),
		.pll_lock (pll_lock)
	);

	// Divided clocks and system reset
	serdes_crg u_crg (
		.clk_4x   (clk_4x),
		.pll_lock (pll_lock),
		.clk_1x   (clk_1x),
		.clk_2x   (clk_2x),
		.rst      (rst)
	);

	// Word alignment strobes
	// Both domains use the same slow clock so the serializer and the
	// capture side agree on where a word starts

	// Output side, fast clock domain
	serdes_sync u_sync_4x (
		.clk_slow (clk_1x),
		.clk_fast (clk_4x),
		.rst      (rst),
		.sync     (sync_4x)
	);

	// Read capture side, delayed clock domain
	serdes_sync u_sync_rd (
		.clk_slow (clk_1x),
		.clk_fast (clk_rd),
		.rst      (rst),
		.sync     (sync_rd)
	);

endmodule

`default_nettype wire

/* tb/sysmgr_clkgen.sv */
`default_nettype none

module sysmgr_clkgen (
	output logic clk,
	output logic por
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam real half_period = 4.0;
	localparam int  por_cycles  = 10;

	// Board clock, 8 ns period
	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	// Power-on reset, released just after a rising edge
	initial begin
		por = 1'b1;
		repeat (por_cycles) @(posedge clk);
		#1 por = 1'b0;
	end

endmodule

`default_nettype wire

/* tb/tb_sysmgr.sv */
`default_nettype none

module tb_sysmgr;

	timeunit 1ns;
	timeprecision 1ps;

	import sysmgr_pkg::*;

	logic       clk_in;
	logic       por;
	logic       test_reset;
	logic       reset;
	logic [3:0] delay;
	logic       clk_1x;
	logic       clk_2x;
	logic       clk_4x;
	logic       clk_rd;
	logic       sync_4x;
	logic       sync_rd;
	logic       rst;

	string       tr_name[$];
	int          tr_delay[$];
	int          tr_rlen[$];
	int          tr_lag[$];
	string       cur_test;
	int          checks;
	int          errors;
	int          n_sync_4x;
	int          n_sync_rd;
	int          cycle_cnt;
	int          cycle_limit;

	sysmgr_clkgen u_clkgen (
		.clk (clk_in),
		.por (por)
	);

	assign reset = por | test_reset;

	sysmgr u_sysmgr (
		.clk_in  (clk_in),
		.reset   (reset),
		.delay   (delay),
		.clk_1x  (clk_1x),
		.clk_2x  (clk_2x),
		.clk_4x  (clk_4x),
		.clk_rd  (clk_rd),
		.sync_4x (sync_4x),
		.sync_rd (sync_rd),
		.rst     (rst)
	);

	// Strobe pulse counters
	initial begin
		n_sync_4x = 0;
		n_sync_rd = 0;
	end

	always @(posedge sync_4x) n_sync_4x++;
	always @(posedge sync_rd) n_sync_rd++;

	task automatic expect_bit(input string what, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s %s: expected %b, actual %b", cur_test, what, exp, act);
		end
	endtask

	task automatic check_count(input string what, input int lo, input int hi, input int act);
		checks++;
		if (act < lo || act > hi) begin
			errors++;
			if (lo == hi) begin
				$display("FAILED %s %s: expected %0d, actual %0d", cur_test, what, lo, act);
			end else begin
				$display("FAILED %s %s: expected %0d..%0d, actual %0d",
					cur_test, what, lo, hi, act);
			end
		end
	endtask

	task automatic match_lag(input string what, input real exp_ps, input real act_ps);
		checks++;
		if (act_ps - exp_ps > 1.0 || exp_ps - act_ps > 1.0) begin
			errors++;
			$display("FAILED %s %s: expected %0.1f ps, actual %0.1f ps",
				cur_test, what, exp_ps, act_ps);
		end
	endtask

	task automatic verify_state(input string what, input crg_state_t exp,
		input crg_state_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s %s: expected %s, actual %s",
				cur_test, what, exp.name(), act.name());
		end
	endtask

	task automatic load_trace();
		int    fd;
		int    n;
		string line;
		string name;
		int    dly;
		int    rlen;
		int    lag;
		fd = $fopen("tb/sysmgr_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open tb/sysmgr_trace.txt for reading");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 1 && line[0] != "#") begin
				n = $sscanf(line, "%s %d %d %d", name, dly, rlen, lag);
				if (n == 4) begin
					tr_name.push_back(name);
					tr_delay.push_back(dly);
					tr_rlen.push_back(rlen);
					tr_lag.push_back(lag);
				end else begin
					$display("Trace line could not be parsed: %s", line);
					errors++;
				end
			end
		end
		$fclose(fd);
	endtask

	// Rising edges of the divided clocks over 64 fast clock edges
	task automatic count_divided_edges();
		int   n_2x;
		int   n_1x;
		logic prev_2x;
		logic prev_1x;
		n_2x = 0;
		n_1x = 0;
		@(negedge clk_4x);
		prev_2x = clk_2x;
		prev_1x = clk_1x;
		repeat (64) begin
			@(negedge clk_4x);
			if (clk_2x === 1'b1 && prev_2x === 1'b0) n_2x++;
			if (clk_1x === 1'b1 && prev_1x === 1'b0) n_1x++;
			prev_2x = clk_2x;
			prev_1x = clk_1x;
		end
		check_count("clk_2x edges in 64 clk_4x edges", 32, 32, n_2x);
		check_count("clk_1x edges in 64 clk_4x edges", 16, 16, n_1x);
	endtask

	// Cycle index counted from the clk_1x rising edge, sampled mid-cycle
	task automatic sync_4x_phase();
		int i;
		@(posedge clk_1x);
		for (i = 0; i < 16; i++) begin
			@(negedge clk_4x);
			expect_bit($sformatf("sync_4x in clk_4x cycle %0d", i % 4),
				(i % 4) == sync_phase, sync_4x);
		end
	endtask

	// One strobe per slow period, always on the same read clock cycle
	task automatic sync_rd_phase();
		int p;
		int i;
		int hits;
		int pos;
		int first_pos;
		first_pos = -1;
		@(posedge clk_1x);
		for (p = 0; p < 4; p++) begin
			hits = 0;
			pos = -1;
			for (i = 0; i < 4; i++) begin
				@(negedge clk_rd);
				if (sync_rd === 1'b1) begin
					hits++;
					pos = i;
				end
			end
			check_count("sync_rd strobes per clk_1x period", 1, 1, hits);
			if (p == 0) begin
				first_pos = pos;
			end else begin
				check_count("sync_rd clk_rd cycle index", first_pos, first_pos, pos);
			end
		end
	endtask

	task automatic measure_lag(input int exp_ps);
		realtime t_4x;
		realtime t_rd;
		@(posedge clk_4x);
		t_4x = $realtime;
		@(posedge clk_rd);
		t_rd = $realtime;
		match_lag("clk_rd lag", real'(exp_ps), (t_rd - t_4x) * 1000.0);
	endtask

	task automatic run_test(input int t);
		int   n;
		int   cycles;
		int   base_4x;
		int   base_rd;
		int   lo;
		int   hi;
		logic prev_1x;
		bit   state_seen;
		cur_test = tr_name[t];
		check_count("trace lag against delay step", tr_delay[t] * delay_step_ps,
			tr_delay[t] * delay_step_ps, tr_lag[t]);

		@(posedge clk_in);
		#1;
		delay = 4'(tr_delay[t]);
		test_reset = 1'b1;

		// Re-entry from a running system
		if (t > 0) begin
			n = 0;
			while (rst !== 1'b1 && n < 12) begin
				@(negedge clk_in);
				n++;
			end
			if (rst !== 1'b1) begin
				$display("%s: rst did not rise within three clk_1x periods of reset",
					cur_test);
				errors++;
			end
		end
		base_4x = n_sync_4x;
		base_rd = n_sync_rd;
		repeat (tr_rlen[t]) begin
			@(negedge clk_in);
			expect_bit("rst while reset is high", 1'b1, rst);
		end
		@(posedge clk_in);
		#1;
		test_reset = 1'b0;

		// Lock count, then hold count in slow clock cycles
		lo = int'(pll_lock_cycles) + 4 * int'(rst_hold_cycles);
		hi = lo + 8;
		cycles = 0;
		state_seen = 1'b0;
		prev_1x = clk_1x;
		while (rst === 1'b1 && cycles < hi + 4) begin
			@(posedge clk_in);
			cycles++;
			@(negedge clk_in);
			if (!state_seen && clk_1x === 1'b1 && prev_1x === 1'b0) begin
				verify_state("state at first clk_1x edge", crg_wait_lock, u_sysmgr.u_crg.state);
				state_seen = 1'b1;
			end
			prev_1x = clk_1x;
		end
		if (rst === 1'b1) begin
			$display("%s: rst still high %0d clk_in cycles after reset release",
				cur_test, cycles);
			errors++;
			return;
		end
		check_count("clk_in cycles to rst release", lo, hi, cycles);
		if (!state_seen) begin
			$display("%s: clk_1x never restarted before rst release", cur_test);
			errors++;
		end
		check_count("sync_4x pulses while rst high", 0, 0, n_sync_4x - base_4x);
		check_count("sync_rd pulses while rst high", 0, 0, n_sync_rd - base_rd);

		count_divided_edges();
		sync_4x_phase();
		sync_rd_phase();
		measure_lag(tr_lag[t]);

		// Random idle time before the next test
		repeat ($urandom_range(7, 0)) @(posedge clk_in);
	endtask

	// Watchdog
	initial begin
		cycle_cnt = 0;
		wait (cycle_limit > 0);
		while (cycle_cnt < cycle_limit) begin
			@(posedge clk_in);
			cycle_cnt++;
		end
		$display("Timeout: run did not finish within %0d clk_in cycles", cycle_limit);
		$display("checks %0d, errors %0d", checks, errors);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		test_reset = 1'b1;
		delay = 4'd0;
		checks = 0;
		errors = 0;
		cycle_limit = 0;
		void'($urandom(32'h3ff2dde0));

		load_trace();
		if (tr_name.size() == 0) begin
			$display("No tests found in the trace");
			errors++;
		end
		cycle_limit = tr_name.size() *
			(int'(pll_lock_cycles) + 4 * int'(rst_hold_cycles) + 200);

		wait (por == 1'b0);
		for (int t = 0; t < tr_name.size(); t++) begin
			run_test(t);
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sysmgr.f */
src/sysmgr_pkg.sv
src/pll_model.sv
src/serdes_crg.sv
src/serdes_sync.sv
src/sysmgr.sv
tb/sysmgr_clkgen.sv
tb/tb_sysmgr.sv

/* tb/sysmgr_trace.txt */
# test_name  delay_code  reset_cycles  expected_lag_ps
# reset_cycles is the extra reset length in clk_in cycles
dly_00    0   4     0
dly_05    5  12   750
dly_01    1   2   150
dly_15   15  16  2250
dly_08    8   6  1200
dly_03    3   9   450
dly_12   12   3  1800
dly_02    2  14   300
dly_10   10   5  1500
dly_06    6  11   900
dly_14   14   2  2100
dly_04    4   8   600
dly_09    9  13  1350
dly_13   13   7  1950
dly_07    7  10  1050
dly_11   11  15  1650
